//--- logic/cdi_loader_pkg.sv
package cdi_loader_pkg;

    // ==============================
    // Widths and constants
    // ==============================

    // SDRAM address counts bytes, bit 0 selects the byte in a word
    localparam int sdram_addr_w = 25;
    localparam int data_w = 16;
    localparam int worm_addr_w = 13;

    // Download index bit that marks the slave image
    localparam int worm_index_bit = 6;

    // Prefix of the ROM region inside SDRAM
    localparam logic [2:0] rom_region_tag = 3'b001;

    // ==============================
    // Vector types
    // ==============================

    typedef logic [sdram_addr_w-1:0] sdram_addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [7:0] byte_t;
    typedef logic [worm_addr_w-1:0] worm_addr_t;

    // ==============================
    // Bundles
    // ==============================

    // Host download channel
    typedef struct packed {
        logic download;
        logic wr;
        sdram_addr_t addr;
        data_t dout;
        data_t index;
    } ioctl_bus_t;

    // One request towards the SDRAM controller
    typedef struct packed {
        sdram_addr_t addr;
        data_t din;
        logic rd;
        logic wr;
        logic word;
        logic refresh;
        logic burst;
    } sdram_req_t;

    // Byte write into the write-once memory of the slave
    typedef struct packed {
        worm_addr_t adr;
        byte_t data;
        logic wr;
    } worm_wr_t;

    // Owner of the SDRAM port while the core is held, in priority order
    typedef enum logic [1:0] {
        ROM_DOWNLOAD,
        REFRESH,
        IDLE
    } prep_owner_e;

endpackage

//--- logic/ioctl_dispatch.sv
`timescale 1ns/10ps

module ioctl_dispatch (
    input logic clk_sys,
    input logic reset,
    input cdi_loader_pkg::ioctl_bus_t ioctl,
    input logic rom_done,
    output logic rom_pending,
    output logic worm_strobe,
    output logic download_overflow
);
    import cdi_loader_pkg::*;

    logic slave_image;
    logic main_rom_wr;

    // Index 0x0000 is the boot ROM, index 0x0040 the slave image
    assign slave_image = ioctl.index[worm_index_bit];
    assign main_rom_wr = ioctl.wr && !slave_image;

    // Slave words go straight to the byte writer in the same cycle
    assign worm_strobe = ioctl.wr && slave_image;

    // ==============================
    // Pending ROM write latch
    // ==============================

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rom_pending <= 1'b0;
        end else if (main_rom_wr) begin
            rom_pending <= 1'b1;
        end else if (rom_done) begin
            rom_pending <= 1'b0;
        end
    end

    // Host wrote again before the previous word reached SDRAM
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            download_overflow <= 1'b0;
        end else if (rom_pending && ioctl.wr) begin
            download_overflow <= 1'b1;
        end
    end

endmodule

//--- logic/worm_byte_writer.sv
`timescale 1ns/10ps

module worm_byte_writer (
    input logic clk_sys,
    input logic reset,
    input cdi_loader_pkg::ioctl_bus_t ioctl,
    input logic worm_strobe,
    output cdi_loader_pkg::worm_wr_t worm
);
    import cdi_loader_pkg::*;

    logic strobe_q;
    logic worm_wr;
    worm_addr_t worm_adr;
    byte_t worm_data;
    // Upper byte waits here while the lower one is written
    byte_t high_byte;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            strobe_q <= 1'b0;
            worm_wr <= 1'b0;
        end else begin
            strobe_q <= worm_strobe;
            worm_wr <= worm_strobe || strobe_q;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (worm_strobe) begin
            // Lower byte first
            worm_adr <= ioctl.addr[worm_addr_w-1:0];
            worm_data <= ioctl.dout[7:0];
            high_byte <= ioctl.dout[15:8];
        end else begin
            worm_adr[0] <= 1'b1;
            worm_data <= high_byte;
        end
    end

    assign worm = '{adr: worm_adr, data: worm_data, wr: worm_wr};

endmodule

//--- logic/sdram_prepare_arbiter.sv
`timescale 1ns/10ps

module sdram_prepare_arbiter (
    input logic clk_sys,
    input logic reset,
    input logic hold,
    input logic rom_pending,
    input cdi_loader_pkg::ioctl_bus_t ioctl,
    input logic sdram_busy,
    output cdi_loader_pkg::sdram_req_t prep_req,
    output logic rom_done
);
    import cdi_loader_pkg::*;

    prep_owner_e owner_q;
    prep_owner_e owner_next;
    logic busy_q;
    logic rom_wanted;
    sdram_addr_t rom_addr;
    data_t rom_data;

    // ==============================
    // Completion
    // ==============================

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= sdram_busy;
        end
    end

    // Busy falls on a write that this block issued
    assign rom_done = busy_q && !sdram_busy && (owner_q == ROM_DOWNLOAD);

    // The latch still reads high in the completion cycle
    assign rom_wanted = rom_pending && !rom_done;

    // ==============================
    // Owner select
    // ==============================

    always_comb begin
        if (sdram_busy) begin
            owner_next = owner_q;
        end else if (hold && rom_wanted) begin
            owner_next = ROM_DOWNLOAD;
        end else if (hold) begin
            owner_next = REFRESH;
        end else begin
            owner_next = IDLE;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            owner_q <= IDLE;
        end else begin
            owner_q <= owner_next;
        end
    end

    // ==============================
    // Request
    // ==============================

    // ROM words keep host address bits 21..1, bytes swapped for the core
    assign rom_addr = {rom_region_tag, ioctl.addr[21:1], 1'b0};
    assign rom_data = {ioctl.dout[7:0], ioctl.dout[15:8]};

    always_comb begin
        prep_req = '0;
        prep_req.addr = rom_addr;
        prep_req.din = rom_data;
        prep_req.word = 1'b1;
        // Nothing new goes out while the controller is busy
        if (!sdram_busy) begin
            prep_req.wr = (owner_next == ROM_DOWNLOAD);
            prep_req.rd = (owner_next == REFRESH);
            prep_req.refresh = (owner_next == REFRESH);
        end
    end

endmodule

//--- logic/sdram_request_select.sv
`timescale 1ns/10ps

module sdram_request_select (
    input logic clk_sys,
    input logic reset,
    input logic status_reset,
    input logic user_button,
    input logic download,
    input cdi_loader_pkg::sdram_req_t prep_req,
    input cdi_loader_pkg::sdram_req_t core_req,
    output logic hold,
    output cdi_loader_pkg::sdram_req_t sdram_req
);

    // ==============================
    // Core hold
    // ==============================

    // Any reset source or a running download keeps the core stopped.
    // The loader owns the SDRAM port for as long as this is high.
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hold <= 1'b1;
        end else begin
            hold <= status_reset || user_button || download;
        end
    end

    // ==============================
    // Port select
    // ==============================

    // Same-cycle pass-through of the core request once the hold ends
    always_comb begin
        if (hold) begin
            sdram_req = prep_req;
        end else begin
            sdram_req = core_req;
        end
    end

endmodule

//--- logic/cdi_loader_top.sv
`timescale 1ns/10ps

module cdi_loader_top (
    input logic clk_sys,
    input logic reset,
    input cdi_loader_pkg::ioctl_bus_t ioctl,
    input logic status_reset,
    input logic user_button,
    input cdi_loader_pkg::sdram_req_t core_req,
    input logic sdram_busy,
    output cdi_loader_pkg::sdram_req_t sdram_req,
    output cdi_loader_pkg::worm_wr_t worm,
    output logic core_reset,
    output logic download_overflow
);
    import cdi_loader_pkg::*;

    logic rom_pending;
    logic worm_strobe;
    logic rom_done;
    logic hold;
    sdram_req_t prep_req;

    // ==============================
    // Download decode
    // ==============================

    ioctl_dispatch u_ioctl_dispatch (
        .clk_sys(clk_sys),
        .reset(reset),
        .ioctl(ioctl),
        .rom_done(rom_done),
        .rom_pending(rom_pending),
        .worm_strobe(worm_strobe),
        .download_overflow(download_overflow)
    );

    // Slave image, two byte writes per word
    worm_byte_writer u_worm_byte_writer (
        .clk_sys(clk_sys),
        .reset(reset),
        .ioctl(ioctl),
        .worm_strobe(worm_strobe),
        .worm(worm)
    );

    // ==============================
    // SDRAM side
    // ==============================

    sdram_prepare_arbiter u_sdram_prepare_arbiter (
        .clk_sys(clk_sys),
        .reset(reset),
        .hold(hold),
        .rom_pending(rom_pending),
        .ioctl(ioctl),
        .sdram_busy(sdram_busy),
        .prep_req(prep_req),
        .rom_done(rom_done)
    );

    sdram_request_select u_sdram_request_select (
        .clk_sys(clk_sys),
        .reset(reset),
        .status_reset(status_reset),
        .user_button(user_button),
        .download(ioctl.download),
        .prep_req(prep_req),
        .core_req(core_req),
        .hold(hold),
        .sdram_req(sdram_req)
    );

    // The core stays in reset exactly as long as the loader owns SDRAM
    assign core_reset = hold;

endmodule

//--- testbench/tb_sdram_responder.sv
`timescale 1ns/10ps

module tb_sdram_responder #(
    parameter logic [31:0] seed = 32'd1
) (
    input logic clk_sys,
    input logic reset,
    input cdi_loader_pkg::sdram_req_t sdram_req,
    output logic sdram_busy
);
    import cdi_loader_pkg::*;

    logic [31:0] rng_state = seed;
    // Remaining busy cycles of the request in flight
    logic [2:0] busy_left = 3'd0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Accept when idle and rd or wr is up, then stay busy 2 to 5 cycles
    always @(posedge clk_sys) begin
        if (reset) begin
            busy_left <= 3'd0;
        end else if (busy_left != 3'd0) begin
            busy_left <= busy_left - 3'd1;
        end else if (sdram_req.rd === 1'b1 || sdram_req.wr === 1'b1) begin
            rng_state <= xorshift32(rng_state);
            busy_left <= 3'd2 + {1'b0, rng_state[1:0]};
        end
    end

    assign sdram_busy = (busy_left != 3'd0);

endmodule

//--- testbench/tb_cdi_loader.sv
`timescale 1ns/10ps

module tb_cdi_loader;
    import cdi_loader_pkg::*;

    localparam int max_cycles = 5000;

    typedef enum {
        PH_SETUP,
        PH_REFRESH,
        PH_ROM,
        PH_WORM,
        PH_OVERFLOW,
        PH_CORE
    } phase_e;

    logic clk_sys;
    logic reset;
    ioctl_bus_t ioctl;
    logic status_reset;
    logic user_button;
    sdram_req_t core_req;
    logic sdram_busy;
    sdram_req_t sdram_req;
    worm_wr_t worm;
    logic core_reset;
    logic download_overflow;

    phase_e phase = PH_SETUP;
    int unsigned cycle = 0;
    logic [31:0] rng_state = 32'd5850;

    // Scoreboard state, owned by the monitor
    logic hold_known = 1'b0;
    logic exp_hold;
    sdram_addr_t exp_rom_addr;
    data_t exp_rom_data;
    int rom_accepts = 0;
    int refresh_accepts = 0;
    int worm_cyc_q[$];
    worm_wr_t worm_exp_q[$];

    cdi_loader_top u_dut (
        .clk_sys(clk_sys),
        .reset(reset),
        .ioctl(ioctl),
        .status_reset(status_reset),
        .user_button(user_button),
        .core_req(core_req),
        .sdram_busy(sdram_busy),
        .sdram_req(sdram_req),
        .worm(worm),
        .core_reset(core_reset),
        .download_overflow(download_overflow)
    );

    tb_sdram_responder #(.seed(32'd5850)) u_responder (
        .clk_sys(clk_sys),
        .reset(reset),
        .sdram_req(sdram_req),
        .sdram_busy(sdram_busy)
    );

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic sdram_addr_t pick_addr();
        logic [31:0] r;
        r = next_random();
        return r[sdram_addr_w-1:0];
    endfunction

    function automatic data_t pick_data();
        logic [31:0] r;
        r = next_random();
        return r[data_w-1:0];
    endfunction

    function automatic sdram_req_t make_core_req();
        logic [63:0] r;
        r = {next_random(), next_random()};
        return r[$bits(sdram_req_t)-1:0];
    endfunction

    // ROM words land in the region tagged 001, bytes swapped for the core
    function automatic sdram_addr_t rom_word_addr(input sdram_addr_t host_addr);
        return {3'b001, host_addr[21:1], 1'b0};
    endfunction

    function automatic data_t rom_word_data(input data_t host_data);
        return {host_data[7:0], host_data[15:8]};
    endfunction

    // Low byte first, then high byte at the odd address
    function automatic worm_wr_t worm_byte_expect(input sdram_addr_t host_addr,
                                                  input data_t host_data,
                                                  input logic upper);
        worm_wr_t w;
        w.wr = 1'b1;
        w.adr = host_addr[12:0];
        w.data = host_data[7:0];
        if (upper) begin
            w.adr[0] = 1'b1;
            w.data = host_data[15:8];
        end
        return w;
    endfunction

    task automatic fail_run(input string what);
        $display("Verification failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            fail_run("value mismatch");
        end
    endtask

    // ==============================
    // Clock, cycle limit
    // ==============================

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            fail_run("timeout, the run did not finish within the cycle limit");
        end
    end

    // ==============================
    // Monitor
    // ==============================

    task automatic check_prepared();
        if ($isunknown({sdram_req.rd, sdram_req.wr, sdram_busy})) begin
            fail_run("prepared request has unknown rd or wr while the core is held");
        end
        if (sdram_busy) begin
            check_value("sdram_req.rd", 1'b0, sdram_req.rd);
            check_value("sdram_req.wr", 1'b0, sdram_req.wr);
        end else if (sdram_req.wr) begin
            if (phase == PH_REFRESH) begin
                fail_run("write request seen while only refresh was expected");
            end
            check_value("sdram_req.addr", exp_rom_addr, sdram_req.addr);
            check_value("sdram_req.din", exp_rom_data, sdram_req.din);
            check_value("sdram_req.rd", 1'b0, sdram_req.rd);
            check_value("sdram_req.word", 1'b1, sdram_req.word);
            check_value("sdram_req.burst", 1'b0, sdram_req.burst);
            rom_accepts++;
        end else if (sdram_req.rd) begin
            check_value("sdram_req.refresh", 1'b1, sdram_req.refresh);
            check_value("sdram_req.word", 1'b1, sdram_req.word);
            check_value("sdram_req.burst", 1'b0, sdram_req.burst);
            refresh_accepts++;
        end
    endtask

    task automatic check_worm();
        if (worm_cyc_q.size() > 0 && worm_cyc_q[0] == cycle) begin
            check_value("worm.wr", worm_exp_q[0].wr, worm.wr);
            check_value("worm.adr", worm_exp_q[0].adr, worm.adr);
            check_value("worm.data", worm_exp_q[0].data, worm.data);
            void'(worm_cyc_q.pop_front());
            void'(worm_exp_q.pop_front());
        end else begin
            check_value("worm.wr", 1'b0, worm.wr);
        end
    endtask

    // Outputs are stable mid-cycle, inputs were driven at the last rising edge
    always @(negedge clk_sys) begin
        if (hold_known) begin
            check_value("core_reset", exp_hold, core_reset);
        end
        exp_hold = reset || status_reset || user_button || ioctl.download;
        hold_known = 1'b1;
        if (!reset) begin
            check_worm();
            if (core_reset === 1'b1) begin
                check_prepared();
            end else begin
                check_value("sdram_req", core_req, sdram_req);
            end
            // Expectations for writes the DUT takes at the next edge
            if (ioctl.wr === 1'b1 && ioctl.index[6]) begin
                worm_cyc_q.push_back(cycle + 1);
                worm_exp_q.push_back(worm_byte_expect(ioctl.addr, ioctl.dout, 1'b0));
                worm_cyc_q.push_back(cycle + 2);
                worm_exp_q.push_back(worm_byte_expect(ioctl.addr, ioctl.dout, 1'b1));
            end else if (ioctl.wr === 1'b1) begin
                exp_rom_addr = rom_word_addr(ioctl.addr);
                exp_rom_data = rom_word_data(ioctl.dout);
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    task automatic write_word(input data_t index, input sdram_addr_t addr, input data_t dout);
        @(posedge clk_sys);
        ioctl.wr <= 1'b1;
        ioctl.index <= index;
        ioctl.addr <= addr;
        ioctl.dout <= dout;
        @(posedge clk_sys);
        ioctl.wr <= 1'b0;
    endtask

    // Returns mid-cycle, a couple of cycles after the write has left the port
    task automatic wait_rom_done(input int target);
        while (rom_accepts < target) begin
            @(negedge clk_sys);
        end
        do begin
            @(negedge clk_sys);
        end while (sdram_busy);
        repeat (2) @(negedge clk_sys);
    endtask

    task automatic pulse_level(input int which, input int len);
        @(posedge clk_sys);
        status_reset <= (which == 0);
        user_button <= (which == 1);
        ioctl.download <= (which == 2);
        repeat (len) @(posedge clk_sys);
        status_reset <= 1'b0;
        user_button <= 1'b0;
        ioctl.download <= 1'b0;
        repeat (3) @(posedge clk_sys);
    endtask

    initial begin
        sdram_addr_t addr;
        data_t dout;
        int refresh_base;
        int rom_base;
        reset = 1'b1;
        ioctl = '0;
        status_reset = 1'b0;
        user_button = 1'b0;
        core_req = '0;
        repeat (4) @(posedge clk_sys);
        reset <= 1'b0;
        repeat (3) @(posedge clk_sys);

        // Each hold source on its own, exact timing checked by the monitor
        pulse_level(0, 3);
        pulse_level(1, 2);
        pulse_level(2, 2);

        // Held core with nothing to download
        phase = PH_REFRESH;
        refresh_base = refresh_accepts;
        @(posedge clk_sys);
        status_reset <= 1'b1;
        repeat (60) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("refresh seen", 1'b1, refresh_accepts > refresh_base);
        @(posedge clk_sys);
        status_reset <= 1'b0;
        ioctl.download <= 1'b1;

        phase = PH_ROM;
        for (int i = 0; i < 40; i++) begin
            addr = pick_addr();
            dout = pick_data();
            write_word(16'h0000, addr, dout);
            wait_rom_done(i + 1);
            check_value("rom write count", i + 1, rom_accepts);
            check_value("download_overflow", 1'b0, download_overflow);
        end

        phase = PH_WORM;
        for (int i = 0; i < 16; i++) begin
            addr = pick_addr();
            dout = pick_data();
            write_word(16'h0040, addr, dout);
            repeat (3) @(posedge clk_sys);
        end
        repeat (4) @(negedge clk_sys);
        check_value("worm writes left", 0, worm_cyc_q.size());

        // Second word while the first still waits for SDRAM
        phase = PH_OVERFLOW;
        addr = pick_addr();
        dout = pick_data();
        rom_base = rom_accepts;
        @(posedge clk_sys);
        ioctl.wr <= 1'b1;
        ioctl.index <= 16'h0000;
        ioctl.addr <= addr;
        ioctl.dout <= dout;
        repeat (2) @(posedge clk_sys);
        ioctl.wr <= 1'b0;
        wait_rom_done(rom_base + 1);
        check_value("rom write count", rom_base + 1, rom_accepts);
        check_value("download_overflow", 1'b1, download_overflow);
        repeat (20) @(negedge clk_sys);
        check_value("download_overflow", 1'b1, download_overflow);

        phase = PH_CORE;
        @(posedge clk_sys);
        ioctl.download <= 1'b0;
        while (core_reset !== 1'b0) begin
            @(negedge clk_sys);
        end
        repeat (100) begin
            @(posedge clk_sys);
            core_req <= make_core_req();
        end
        repeat (3) @(negedge clk_sys);
        check_value("download_overflow", 1'b1, download_overflow);

        $display("Verification passed");
        $finish;
    end

endmodule

//--- all.f
logic/cdi_loader_pkg.sv
logic/ioctl_dispatch.sv
logic/worm_byte_writer.sv
logic/sdram_prepare_arbiter.sv
logic/sdram_request_select.sv
logic/cdi_loader_top.sv
testbench/tb_sdram_responder.sv
testbench/tb_cdi_loader.sv

//--- Makefile
VERILATOR ?= verilator
FILE_LIST ?= all.f
TB_TOP ?= tb_cdi_loader
RTL_TOP ?= cdi_loader_top
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing

.PHONY: lint sim build clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	-$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
